//--- list.f
+incdir+.
adc_pkg.sv
report_pkg.sv
analogue_infrastructure.sv
adc_scan_sequencer.sv
sample_averager.sv
limit_checker.sv
credit_fifo.sv
report_merge.sv
analog_monitor_top.sv
tb_analog_monitor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_analog_monitor
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_analog_monitor.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module tb_analog_monitor;

  // slow conversions take about 140 cycles and four make a record
  localparam int TOTAL_RECORDS  = 37;
  localparam int TIMEOUT_CYCLES = TOTAL_RECORDS * 4 * 140 + 10000;
  localparam adc_pkg::chan_t ALARM_SRC = 5'd24;
  localparam adc_pkg::chan_t MULTI_SRC [5] = '{5'd2, 5'd11, 5'd17, 5'd23, 5'd29};

  logic                                      sys_clk;
  logic                                      rst_n;
  logic                                      fast_mode;
  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] av;
  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] ac;
  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] at;
  logic [`MON_NUM_SRC-1:0]                   scan_en;
  logic [1:0]                                cfg_addr;
  adc_pkg::sample_t                          cfg_wdata;
  logic                                      cfg_wen;
  adc_pkg::sample_t                          cfg_rdata;
  logic                                      rep_credit;
  logic                                      rep_valid;
  report_pkg::rep_kind_t                     rep_kind;
  adc_pkg::chan_t                            rep_chan;
  adc_pkg::sample_t                          rep_value;

  // records seen on the output stream in arrival order
  report_pkg::rep_kind_t kind_q[$];
  adc_pkg::chan_t        chan_q[$];
  adc_pkg::sample_t      value_q[$];

  adc_pkg::chan_t   scan_list[$];
  adc_pkg::sample_t src_val [`MON_NUM_SRC];
  adc_pkg::sample_t multi_val [5];
  logic [31:0]      lcg_state;
  logic             hold_credits;
  logic [1:0]       credit_pipe;
  logic             next_credit;
  int               owed_credits;
  int               cycle_count;
  int               errors;
  int               err_mark;
  int               tests_passed;
  int               tests_failed;

  analog_monitor_top dut (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .fast_mode  (fast_mode),
    .av         (av),
    .ac         (ac),
    .at         (at),
    .scan_en    (scan_en),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_wen    (cfg_wen),
    .cfg_rdata  (cfg_rdata),
    .rep_credit (rep_credit),
    .rep_valid  (rep_valid),
    .rep_kind   (rep_kind),
    .rep_chan   (rep_chan),
    .rep_value  (rep_value)
  );

  initial sys_clk = 1'b0;
  always #10 sys_clk = ~sys_clk;

  // sink model takes records mid-cycle and returns credits two cycles later
  always @(negedge sys_clk) begin
    if (!rst_n) begin
      credit_pipe  = '0;
      owed_credits = 0;
      next_credit  = 1'b0;
    end else begin
      next_credit = credit_pipe[1];
      if (!next_credit && !hold_credits && owed_credits > 0) begin
        next_credit = 1'b1;
        owed_credits--;
      end
      if (rep_valid) begin
        kind_q.push_back(rep_kind);
        chan_q.push_back(rep_chan);
        value_q.push_back(rep_value);
        if (hold_credits) begin
          owed_credits++;
        end
      end
      credit_pipe = {credit_pipe[0], rep_valid && !hold_credits};
    end
  end

  always @(posedge sys_clk) begin
    #2;
    rep_credit = next_credit;
  end

  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic adc_pkg::sample_t random_sample();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[27:16];
  endfunction

  function automatic report_pkg::avg_rec_t make_avg(adc_pkg::chan_t c, adc_pkg::sample_t v);
    report_pkg::avg_rec_t r;
    r.chan  = c;
    r.value = v;
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge sys_clk);
    #2;
  endtask

  task automatic reset_dut(logic fast);
    next_cycle();
    rst_n        = 1'b0;
    fast_mode    = fast;
    scan_en      = '0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    cfg_wen      = 1'b0;
    hold_credits = 1'b0;
    av           = '0;
    ac           = '0;
    at           = '0;
    foreach (src_val[i]) begin
      src_val[i] = '0;
    end
    repeat (4) @(posedge sys_clk);
    #2;
    rst_n = 1'b1;
    kind_q.delete();
    chan_q.delete();
    value_q.delete();
  endtask

  task automatic end_test(string name);
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  // 0..9 voltage lanes, 10..19 current, 20..29 temperature
  task automatic set_source(adc_pkg::chan_t ch, adc_pkg::sample_t v);
    int idx;
    idx = int'(ch);
    src_val[idx] = v;
    if (idx < `MON_NUM_CH) begin
      av[idx] = v;
    end else if (idx < 2 * `MON_NUM_CH) begin
      ac[idx - `MON_NUM_CH] = v;
    end else begin
      at[idx - 2 * `MON_NUM_CH] = v;
    end
  endtask

  task automatic write_limit(logic [1:0] addr, adc_pkg::sample_t v);
    next_cycle();
    cfg_addr  = addr;
    cfg_wdata = v;
    cfg_wen   = 1'b1;
    next_cycle();
    cfg_wen = 1'b0;
  endtask

  task automatic read_limit(logic [1:0] addr, output adc_pkg::sample_t v);
    next_cycle();
    cfg_addr = addr;
    #5;
    v = cfg_rdata;
  endtask

  task automatic check_avg(report_pkg::avg_rec_t got, report_pkg::avg_rec_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s average chan %0d value %0d, expected chan %0d value %0d",
               $time, what, got.chan, got.value, exp.chan, exp.value);
    end
  endtask

  task automatic check_alarm(report_pkg::alarm_rec_t got, report_pkg::alarm_rec_t exp,
                             string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s alarm chan %0d sample %0d, expected chan %0d sample %0d",
               $time, what, got.chan, got.sample, exp.chan, exp.sample);
    end
  endtask

  task automatic check_limit(adc_pkg::sample_t got, adc_pkg::sample_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s reads %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic wait_records(int n, int max_cycles, string what, output bit ok);
    int waited;
    waited = 0;
    while (chan_q.size() < n && waited < max_cycles) begin
      @(posedge sys_clk);
      waited++;
    end
    ok = chan_q.size() >= n;
    if (!ok) begin
      errors++;
      $display("%s: only %0d of %0d records arrived within %0d cycles",
               what, chan_q.size(), n, max_cycles);
    end
  endtask

  // four equal samples average to the sample itself
  task automatic take_avg(adc_pkg::chan_t exp_chan, string what);
    report_pkg::rep_kind_t k;
    report_pkg::avg_rec_t  got;
    k         = kind_q.pop_front();
    got.chan  = chan_q.pop_front();
    got.value = value_q.pop_front();
    if (k != report_pkg::rep_avg) begin
      errors++;
      $display("mismatch at %0t: %s is an alarm record, expected an average", $time, what);
    end
    check_avg(got, make_avg(exp_chan, src_val[exp_chan]), what);
  endtask

  // enabled sources come out in ascending round-robin order
  task automatic scan_and_check(int n, string what);
    bit ok;
    next_cycle();
    foreach (scan_list[i]) begin
      scan_en[scan_list[i]] = 1'b1;
    end
    wait_records(n, (n + scan_list.size()) * 4 * 150, what, ok);
    if (ok) begin
      for (int i = 0; i < n; i++) begin
        take_avg(scan_list[i % scan_list.size()], $sformatf("%s record %0d", what, i));
      end
    end
  endtask

  task automatic load_multi_sources();
    scan_list.delete();
    foreach (MULTI_SRC[i]) begin
      scan_list.push_back(MULTI_SRC[i]);
      set_source(MULTI_SRC[i], multi_val[i]);
    end
  endtask

  // first average after a level change may mix old and new samples
  task automatic alarm_phase(int n, int exp_alarms, adc_pkg::sample_t old_level,
                             adc_pkg::sample_t level, string what);
    bit                     ok;
    bit                     first_avg;
    int                     alarms;
    adc_pkg::sample_t       lo;
    adc_pkg::sample_t       hi;
    report_pkg::rep_kind_t  k;
    report_pkg::alarm_rec_t got;
    report_pkg::alarm_rec_t exp;
    alarms     = 0;
    first_avg  = 1'b1;
    lo         = (old_level < level) ? old_level : level;
    hi         = (old_level < level) ? level : old_level;
    exp.chan   = ALARM_SRC;
    exp.sample = level;
    wait_records(n, n * 4 * 150, what, ok);
    if (ok) begin
      for (int i = 0; i < n; i++) begin
        k          = kind_q.pop_front();
        got.chan   = chan_q.pop_front();
        got.sample = value_q.pop_front();
        if (k == report_pkg::rep_alarm) begin
          alarms++;
          check_alarm(got, exp, what);
        end else if (first_avg && old_level != level) begin
          if (got.chan != ALARM_SRC || got.sample < lo || got.sample > hi) begin
            errors++;
            $display("mismatch at %0t: %s average chan %0d value %0d, expected chan %0d in %0d..%0d",
                     $time, what, got.chan, got.sample, ALARM_SRC, lo, hi);
          end
          first_avg = 1'b0;
        end else begin
          check_avg(make_avg(got.chan, got.sample), make_avg(ALARM_SRC, level), what);
          first_avg = 1'b0;
        end
      end
      if (alarms != exp_alarms) begin
        errors++;
        $display("%s: %0d alarm records where %0d were expected", what, alarms, exp_alarms);
      end
    end
  endtask

  task automatic test_idle_and_limits();
    adc_pkg::sample_t wr [3];
    adc_pkg::sample_t got;
    err_mark = errors;
    reset_dut(1'b1);
    repeat (200) @(posedge sys_clk);
    if (chan_q.size() != 0) begin
      errors++;
      $display("idle: %0d records appeared with scanning disabled", chan_q.size());
    end
    for (int k = 0; k < 3; k++) begin
      read_limit(2'(k), got);
      check_limit(got, 12'hfff, $sformatf("reset limit %0d", k));
    end
    for (int k = 0; k < 3; k++) begin
      wr[k] = random_sample();
      write_limit(2'(k), wr[k]);
    end
    for (int k = 0; k < 3; k++) begin
      read_limit(2'(k), got);
      check_limit(got, wr[k], $sformatf("written limit %0d", k));
    end
    end_test("idle_and_limits");
  endtask

  task automatic test_fast_average();
    err_mark = errors;
    reset_dut(1'b1);
    scan_list.delete();
    scan_list.push_back(5'd3);
    set_source(5'd3, 12'h5a3);
    scan_and_check(3, "single source");
    reset_dut(1'b1);
    foreach (multi_val[i]) begin
      multi_val[i] = random_sample();
    end
    load_multi_sources();
    scan_and_check(10, "several sources");
    end_test("fast_average");
  endtask

  task automatic test_alarm();
    adc_pkg::sample_t got;
    err_mark = errors;
    reset_dut(1'b1);
    write_limit(2'(adc_pkg::temp), 12'd2000);
    read_limit(2'(adc_pkg::temp), got);
    check_limit(got, 12'd2000, "temperature limit");
    next_cycle();
    set_source(ALARM_SRC, 12'd2500);
    scan_en[ALARM_SRC] = 1'b1;
    alarm_phase(3, 1, 12'd2500, 12'd2500, "above limit");
    next_cycle();
    set_source(ALARM_SRC, 12'd2000);
    alarm_phase(2, 0, 12'd2500, 12'd2000, "at limit");
    next_cycle();
    set_source(ALARM_SRC, 12'd2600);
    alarm_phase(4, 1, 12'd2000, 12'd2600, "above limit again");
    end_test("alarm");
  endtask

  task automatic test_credits();
    bit ok;
    err_mark = errors;
    reset_dut(1'b1);
    hold_credits = 1'b1;
    scan_list.delete();
    scan_list.push_back(5'd5);
    scan_list.push_back(5'd14);
    set_source(5'd5, random_sample());
    set_source(5'd14, random_sample());
    scan_en[5]  = 1'b1;
    scan_en[14] = 1'b1;
    wait_records(`MON_REPORT_CREDITS, 8 * 4 * 150, "credits withheld", ok);
    // long enough for the average queue to fill and the scan to stall
    repeat (400) @(posedge sys_clk);
    if (kind_q.size() > `MON_REPORT_CREDITS) begin
      errors++;
      $display("credits withheld: %0d records arrived with only %0d credits",
               kind_q.size(), `MON_REPORT_CREDITS);
    end
    for (int i = 0; i < `MON_REPORT_CREDITS && kind_q.size() > 0; i++) begin
      take_avg(scan_list[i % 2], $sformatf("withheld record %0d", i));
    end
    next_cycle();
    hold_credits = 1'b0;
    wait_records(6, 8 * 4 * 150, "credits returned", ok);
    if (ok) begin
      for (int i = `MON_REPORT_CREDITS; i < `MON_REPORT_CREDITS + 6; i++) begin
        take_avg(scan_list[i % 2], $sformatf("resumed record %0d", i));
      end
    end
    end_test("credits");
  endtask

  task automatic test_slow_average();
    err_mark = errors;
    reset_dut(1'b0);
    load_multi_sources();
    scan_and_check(5, "slow mode");
    end_test("slow_average");
  endtask

  initial begin
    rst_n        = 1'b0;
    fast_mode    = 1'b1;
    av           = '0;
    ac           = '0;
    at           = '0;
    scan_en      = '0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    cfg_wen      = 1'b0;
    rep_credit   = 1'b0;
    hold_credits = 1'b0;
    credit_pipe  = '0;
    next_credit  = 1'b0;
    owed_credits = 0;
    lcg_state    = 32'd61530;
    cycle_count  = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_idle_and_limits();
    test_fast_average();
    test_alarm();
    test_credits();
    test_slow_average();
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- analog_monitor_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module analog_monitor_top (
  input  logic                                      sys_clk,
  input  logic                                      rst_n,
  input  logic                                      fast_mode,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] av,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] ac,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0] at,
  input  logic [`MON_NUM_SRC-1:0]                   scan_en,
  input  logic [1:0]                                cfg_addr,
  input  adc_pkg::sample_t                          cfg_wdata,
  input  logic                                      cfg_wen,
  output adc_pkg::sample_t                          cfg_rdata,
  input  logic                                      rep_credit,
  output logic                                      rep_valid,
  output report_pkg::rep_kind_t                     rep_kind,
  output adc_pkg::chan_t                            rep_chan,
  output adc_pkg::sample_t                          rep_value
);

  logic                   adc_start;
  adc_pkg::chan_t         adc_chnum;
  logic                   adc_busy;
  logic                   adc_datavalid;
  adc_pkg::sample_t       adc_result;
  logic                   smp_valid;
  adc_pkg::chan_t         smp_chan;
  adc_pkg::sample_t       smp_value;
  logic                   avg_push;
  report_pkg::avg_rec_t   avg_rec;
  logic                   alarm_push;
  report_pkg::alarm_rec_t alarm_rec;
  report_pkg::avg_rec_t   avg_head;
  report_pkg::alarm_rec_t alarm_head;
  logic                   avg_ready;
  logic                   alarm_ready;
  logic                   room_avg;
  logic                   room_alarm;
  logic                   avg_pop;
  logic                   alarm_pop;

  analogue_infrastructure u_ab (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .fast_mode     (fast_mode),
    .av            (av),
    .ac            (ac),
    .at            (at),
    .adc_start     (adc_start),
    .adc_chnum     (adc_chnum),
    .adc_busy      (adc_busy),
    .adc_datavalid (adc_datavalid),
    .adc_result    (adc_result)
  );

  adc_scan_sequencer u_seq (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .scan_en       (scan_en),
    .room_avg      (room_avg),
    .room_alarm    (room_alarm),
    .adc_busy      (adc_busy),
    .adc_datavalid (adc_datavalid),
    .adc_result    (adc_result),
    .adc_start     (adc_start),
    .adc_chnum     (adc_chnum),
    .smp_valid     (smp_valid),
    .smp_chan      (smp_chan),
    .smp_value     (smp_value)
  );

  sample_averager u_avg (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .smp_valid (smp_valid),
    .smp_chan  (smp_chan),
    .smp_value (smp_value),
    .avg_push  (avg_push),
    .avg_rec   (avg_rec)
  );

  limit_checker u_lim (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .smp_valid  (smp_valid),
    .smp_chan   (smp_chan),
    .smp_value  (smp_value),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_wen    (cfg_wen),
    .cfg_rdata  (cfg_rdata),
    .alarm_push (alarm_push),
    .alarm_rec  (alarm_rec)
  );

  credit_fifo #(.payload_t(report_pkg::avg_rec_t)) u_avg_q (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (avg_push),
    .din       (avg_rec),
    .pop       (avg_pop),
    .dout      (avg_head),
    .not_empty (avg_ready),
    .has_room  (room_avg)
  );

  credit_fifo #(.payload_t(report_pkg::alarm_rec_t)) u_alarm_q (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (alarm_push),
    .din       (alarm_rec),
    .pop       (alarm_pop),
    .dout      (alarm_head),
    .not_empty (alarm_ready),
    .has_room  (room_alarm)
  );

  report_merge u_merge (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .avg_head    (avg_head),
    .avg_ready   (avg_ready),
    .alarm_head  (alarm_head),
    .alarm_ready (alarm_ready),
    .rep_credit  (rep_credit),
    .avg_pop     (avg_pop),
    .alarm_pop   (alarm_pop),
    .rep_valid   (rep_valid),
    .rep_kind    (rep_kind),
    .rep_chan    (rep_chan),
    .rep_value   (rep_value)
  );

endmodule

`default_nettype wire

//--- report_merge.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module report_merge (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  report_pkg::avg_rec_t   avg_head,
  input  logic                   avg_ready,
  input  report_pkg::alarm_rec_t alarm_head,
  input  logic                   alarm_ready,
  input  logic                   rep_credit,
  output logic                   avg_pop,
  output logic                   alarm_pop,
  output logic                   rep_valid,
  output report_pkg::rep_kind_t  rep_kind,
  output adc_pkg::chan_t         rep_chan,
  output adc_pkg::sample_t       rep_value
);

  localparam int CRED_W = $clog2(`MON_REPORT_CREDITS + 1);

  logic [CRED_W-1:0] credits;
  logic              can_send;
  logic              send;

  assign can_send  = credits != '0;
  // alarms go ahead of averages
  assign alarm_pop = can_send && alarm_ready;
  assign avg_pop   = can_send && avg_ready && !alarm_ready;
  assign send      = alarm_pop || avg_pop;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= CRED_W'(`MON_REPORT_CREDITS);
      rep_valid <= 1'b0;
    end else begin
      rep_valid <= send;
      credits   <= credits + CRED_W'(rep_credit) - CRED_W'(send);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (alarm_pop) begin
      rep_kind  <= report_pkg::rep_alarm;
      rep_chan  <= alarm_head.chan;
      rep_value <= alarm_head.sample;
    end else if (avg_pop) begin
      rep_kind  <= report_pkg::rep_avg;
      rep_chan  <= avg_head.chan;
      rep_value <= avg_head.value;
    end
  end

  // a sink returning more than it received
  a_credit_bound: assert property (@(posedge sys_clk) disable iff (!rst_n)
    credits <= CRED_W'(`MON_REPORT_CREDITS));

endmodule

`default_nettype wire

//--- credit_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     sys_clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     not_empty,
  output logic     has_room
);

  localparam int PTR_W = $clog2(`MON_QUEUE_DEPTH);

  payload_t         mem [`MON_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  assign dout      = mem[rd_ptr];
  assign not_empty = count != '0;
  assign has_room  = count != (PTR_W + 1)'(`MON_QUEUE_DEPTH);

  a_no_overflow: assert property (@(posedge sys_clk) disable iff (!rst_n)
    push |-> has_room);

  a_no_underflow: assert property (@(posedge sys_clk) disable iff (!rst_n)
    pop |-> not_empty);

endmodule

`default_nettype wire

//--- limit_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module limit_checker (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  logic                   smp_valid,
  input  adc_pkg::chan_t         smp_chan,
  input  adc_pkg::sample_t       smp_value,
  input  logic [1:0]             cfg_addr,
  input  adc_pkg::sample_t       cfg_wdata,
  input  logic                   cfg_wen,
  output adc_pkg::sample_t       cfg_rdata,
  output logic                   alarm_push,
  output report_pkg::alarm_rec_t alarm_rec
);

  adc_pkg::sample_t [2:0]  limit_q;
  logic [`MON_NUM_SRC-1:0] over_q;
  adc_pkg::kind_t          smp_kind;
  logic                    above;

  function automatic adc_pkg::kind_t kind_of(adc_pkg::chan_t ch);
    if (ch < 5'(`MON_NUM_CH)) begin
      return adc_pkg::volt;
    end else if (ch < 5'(2 * `MON_NUM_CH)) begin
      return adc_pkg::curr;
    end
    return adc_pkg::temp;
  endfunction

  assign smp_kind  = kind_of(smp_chan);
  assign above     = smp_value > limit_q[smp_kind];
  assign cfg_rdata = (cfg_addr == 2'd3) ? '0 : limit_q[cfg_addr];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      limit_q    <= '1;
      over_q     <= '0;
      alarm_push <= 1'b0;
    end else begin
      alarm_push <= 1'b0;
      if (cfg_wen && cfg_addr != 2'd3) begin
        limit_q[cfg_addr] <= cfg_wdata;
      end
      // alarm only on the way into over-limit
      if (smp_valid) begin
        over_q[smp_chan] <= above;
        if (above && !over_q[smp_chan]) begin
          alarm_push <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (smp_valid && above && !over_q[smp_chan]) begin
      alarm_rec.chan   <= smp_chan;
      alarm_rec.sample <= smp_value;
    end
  end

  a_cfg_addr_valid: assert property (@(posedge sys_clk) disable iff (!rst_n)
    cfg_wen |-> cfg_addr != 2'd3);

endmodule

`default_nettype wire

//--- sample_averager.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module sample_averager (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 smp_valid,
  input  adc_pkg::chan_t       smp_chan,
  input  adc_pkg::sample_t     smp_value,
  output logic                 avg_push,
  output report_pkg::avg_rec_t avg_rec
);

  logic [`MON_NUM_SRC-1:0][`MON_ADC_BITS+`MON_AVG_LOG2-1:0] sum_q;
  logic [`MON_NUM_SRC-1:0][`MON_AVG_LOG2-1:0]               cnt_q;
  logic [`MON_ADC_BITS+`MON_AVG_LOG2-1:0]                   sum_new;
  logic                                                     last;

  assign sum_new = sum_q[smp_chan] + {{`MON_AVG_LOG2{1'b0}}, smp_value};

  // counter all ones means this is the fourth sample
  assign last = &cnt_q[smp_chan];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q    <= '0;
      cnt_q    <= '0;
      avg_push <= 1'b0;
    end else begin
      avg_push <= 1'b0;
      if (smp_valid) begin
        if (last) begin
          avg_push        <= 1'b1;
          sum_q[smp_chan] <= '0;
          cnt_q[smp_chan] <= '0;
        end else begin
          sum_q[smp_chan] <= sum_new;
          cnt_q[smp_chan] <= cnt_q[smp_chan] + 1'b1;
        end
      end
    end
  end

  // floor average is the top bits of the sum
  always_ff @(posedge sys_clk) begin
    if (smp_valid && last) begin
      avg_rec.chan  <= smp_chan;
      avg_rec.value <= sum_new[`MON_ADC_BITS+`MON_AVG_LOG2-1:`MON_AVG_LOG2];
    end
  end

endmodule

`default_nettype wire

//--- adc_scan_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module adc_scan_sequencer (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  logic [`MON_NUM_SRC-1:0] scan_en,
  input  logic                    room_avg,
  input  logic                    room_alarm,
  input  logic                    adc_busy,
  input  logic                    adc_datavalid,
  input  adc_pkg::sample_t        adc_result,
  output logic                    adc_start,
  output adc_pkg::chan_t          adc_chnum,
  output logic                    smp_valid,
  output adc_pkg::chan_t          smp_chan,
  output adc_pkg::sample_t        smp_value
);

  adc_pkg::chan_t ptr;
  adc_pkg::chan_t next_src;
  logic           next_found;
  logic           in_flight;
  logic           settle;

  // next enabled source after the pointer with wrap-around
  always_comb begin
    int idx;
    next_found = 1'b0;
    next_src   = ptr;
    for (int i = 1; i <= `MON_NUM_SRC; i++) begin
      idx = (int'(ptr) + i) % `MON_NUM_SRC;
      if (!next_found && scan_en[idx]) begin
        next_found = 1'b1;
        next_src   = adc_pkg::chan_t'(idx);
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr       <= adc_pkg::chan_t'(`MON_NUM_SRC - 1);
      in_flight <= 1'b0;
      settle    <= 1'b0;
      adc_start <= 1'b0;
    end else begin
      adc_start <= 1'b0;
      if (adc_datavalid) begin
        in_flight <= 1'b0;
        settle    <= 1'b1;
      end else if (settle) begin
        // records of the last sample reach the queue counts
        settle <= 1'b0;
      end else if (!in_flight && !adc_busy && next_found && room_avg && room_alarm) begin
        adc_start <= 1'b1;
        in_flight <= 1'b1;
        ptr       <= next_src;
      end
    end
  end

  // pointer holds the channel in flight
  assign adc_chnum = ptr;
  assign smp_valid = adc_datavalid;
  assign smp_chan  = ptr;
  assign smp_value = adc_result;

  a_smp_in_flight: assert property (@(posedge sys_clk) disable iff (!rst_n)
    smp_valid |-> in_flight);

endmodule

`default_nettype wire

//--- analogue_infrastructure.sv
`default_nettype none
`timescale 1ns/1ps

`include "monitor_consts.svh"

module analogue_infrastructure (
  input  logic                                        sys_clk,
  input  logic                                        rst_n,
  input  logic                                        fast_mode,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0]   av,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0]   ac,
  input  logic [`MON_NUM_CH-1:0][`MON_ADC_BITS-1:0]   at,
  input  logic                                        adc_start,
  input  adc_pkg::chan_t                              adc_chnum,
  output logic                                        adc_busy,
  output logic                                        adc_datavalid,
  output adc_pkg::sample_t                            adc_result
);

  logic [7:0] adc_clkdivide;
  logic [7:0] adc_sampletime;
  logic [7:0] conv_len;
  logic [7:0] conv_cnt;
  logic [`MON_NUM_SRC-1:0][`MON_ADC_BITS-1:0] src_all;
  adc_pkg::sample_t sample_q;

  assign adc_clkdivide  = fast_mode ? 8'(`MON_CLKDIV_FAST) : 8'(`MON_CLKDIV_SLOW);
  assign adc_sampletime = fast_mode ? 8'(`MON_STIME_FAST) : 8'(`MON_STIME_SLOW);

  // sample phase plus 12 bit decisions at the divided clock
  assign conv_len = adc_sampletime + 8'd12 * (adc_clkdivide + 8'd1);

  // voltages in the low lanes, temperatures on top
  assign src_all = {at, ac, av};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_busy      <= 1'b0;
      adc_datavalid <= 1'b0;
      conv_cnt      <= '0;
    end else begin
      adc_datavalid <= 1'b0;
      if (adc_start && !adc_busy) begin
        adc_busy <= 1'b1;
        conv_cnt <= conv_len - 8'd2;
      end else if (adc_busy) begin
        if (conv_cnt == 8'd0) begin
          adc_busy      <= 1'b0;
          adc_datavalid <= 1'b1;
        end else begin
          conv_cnt <= conv_cnt - 8'd1;
        end
      end
    end
  end

  // track and hold at start, SAR result at the end
  always_ff @(posedge sys_clk) begin
    if (adc_start && !adc_busy) begin
      sample_q <= (adc_chnum < 5'(`MON_NUM_SRC)) ? src_all[adc_chnum] : '0;
    end
    if (adc_busy && conv_cnt == 8'd0) begin
      adc_result <= sample_q;
    end
  end

  a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
    adc_start |-> !adc_busy);

endmodule

`default_nettype wire

//--- report_pkg.sv
`default_nettype none

package report_pkg;

  typedef struct packed {
    adc_pkg::chan_t   chan;
    adc_pkg::sample_t value;
  } avg_rec_t;

  // sample that crossed the high limit
  typedef struct packed {
    adc_pkg::chan_t   chan;
    adc_pkg::sample_t sample;
  } alarm_rec_t;

  typedef enum logic {
    rep_avg,
    rep_alarm
  } rep_kind_t;

endpackage

`default_nettype wire

//--- adc_pkg.sv
`default_nettype none

`include "monitor_consts.svh"

package adc_pkg;

  // 0..9 voltage, 10..19 current, 20..29 temperature
  typedef logic [4:0] chan_t;

  typedef logic [`MON_ADC_BITS-1:0] sample_t;

  typedef enum logic [1:0] {
    volt,
    curr,
    temp
  } kind_t;

endpackage

`default_nettype wire

//--- monitor_consts.svh
`ifndef MONITOR_CONSTS_SVH
`define MONITOR_CONSTS_SVH

// gate channels and scanned quantities (V, I, T per channel)
`define MON_NUM_CH          10
`define MON_NUM_SRC         30
`define MON_ADC_BITS        12

// ADC clock divide and sample time for fast and slow mode
`define MON_CLKDIV_FAST     0
`define MON_CLKDIV_SLOW     9
`define MON_STIME_FAST      4
`define MON_STIME_SLOW      18

// four-sample average
`define MON_AVG_LOG2        2

// report stream
`define MON_REPORT_CREDITS  4
`define MON_QUEUE_DEPTH     4

`endif
